//--- Bender.yml
package:
  name: rvcore

sources:
  - files:
      - src/rvPkg.sv
      - src/fetchStage.sv
      - src/mainController.sv
      - src/regFile.sv
      - src/decodeStage.sv
      - src/executeStage.sv
      - src/rvCore.sv
  - target: test
    files:
      - tests/rvCore_sva.sv
      - tests/rvCoreTb.sv

//--- sim.f
src/rvPkg.sv
src/fetchStage.sv
src/mainController.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/rvCore.sv
tests/rvCore_sva.sv
tests/rvCoreTb.sv

//--- src/decodeStage.sv
`timescale 1ns/1ns

module decodeStage import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] instr,
    input  logic            fValid,
    input  logic            redirect,
    input  logic            wbEn,
    input  logic [4:0]      wbRd,
    input  logic [xlen-1:0] wbData,
    output logic [xlen-1:0] exPc,
    output logic [xlen-1:0] exRs1Data,
    output logic [xlen-1:0] exRs2Data,
    output logic [xlen-1:0] exImm,
    output logic [2:0]      exFunct3,
    output logic            exFunct7b30,
    output logic [4:0]      exRd,
    output logic            exRegWrite,
    output logic            exMemWrite,
    output logic            exBranch,
    output logic            exJal,
    output logic            exJalr,
    output aluSrcT          exAluSrc,
    output aluOpT           exAluOp,
    output resultSrcT       exResultSrc,
    output logic            dValid
);

    opcodeT          opcode;
    logic            regWrite, memWrite, branch, jal, jalr;
    aluSrcT          aluSrc;
    aluOpT           aluOp;
    immKindT         immKind;
    resultSrcT       resultSrc;
    logic [xlen-1:0] rs1Data, rs2Data;
    logic [xlen-1:0] imm;

    assign opcode = opcodeT'(instr[6:0]);

    mainController ctrl (
        .opcode    (opcode),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .branch    (branch),
        .jal       (jal),
        .jalr      (jalr),
        .aluSrc    (aluSrc),
        .aluOp     (aluOp),
        .immKind   (immKind),
        .resultSrc (resultSrc)
    );

    regFile rf (
        .clk     (clk),
        .rstN    (rstN),
        .rs1     (instr[19:15]),
        .rs2     (instr[24:20]),
        .wbEn    (wbEn),
        .wbRd    (wbRd),
        .wbData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    always_comb begin
        case (immKind)
            immS:    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            immU:    imm = {instr[31:12], 12'b0};
            immJ:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dValid      <= 1'b0;
            exRegWrite  <= 1'b0;
            exMemWrite  <= 1'b0;
            exBranch    <= 1'b0;
            exJal       <= 1'b0;
            exJalr      <= 1'b0;
            exAluSrc    <= srcReg;
            exAluOp     <= aluAdd;
            exResultSrc <= resNone;
        end else begin
            dValid      <= fValid && !redirect;  // flush behind a taken redirect.
            exRegWrite  <= regWrite;
            exMemWrite  <= memWrite;
            exBranch    <= branch;
            exJal       <= jal;
            exJalr      <= jalr;
            exAluSrc    <= aluSrc;
            exAluOp     <= aluOp;
            exResultSrc <= resultSrc;
        end
    end

    always_ff @(posedge clk) begin
        exPc        <= pc;
        exRs1Data   <= rs1Data;
        exRs2Data   <= rs2Data;
        exImm       <= imm;
        exFunct3    <= instr[14:12];
        exFunct7b30 <= instr[30];
        exRd        <= instr[11:7];
    end

endmodule

//--- src/executeStage.sv
`timescale 1ns/1ns

module executeStage import rvPkg::*; (
    input  logic            clk,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1Data,
    input  logic [xlen-1:0] rs2Data,
    input  logic [xlen-1:0] imm,
    input  logic [2:0]      funct3,
    input  logic            funct7b30,
    input  logic [4:0]      rd,
    input  logic            regWrite,
    input  logic            memWrite,
    input  logic            branch,
    input  logic            jal,
    input  logic            jalr,
    input  aluSrcT          aluSrc,
    input  aluOpT           aluOp,
    input  resultSrcT       resultSrc,
    input  logic            dValid,
    output logic            redirect,
    output logic [xlen-1:0] redirectPc,
    output logic            wbEn,
    output logic [4:0]      wbRd,
    output logic [xlen-1:0] wbData,
    output logic            retire,
    output logic [xlen-1:0] retirePc,
    output logic            retireRegWrite,
    output logic [4:0]      retireRd,
    output logic [xlen-1:0] retireData,
    output logic            storeEn,
    output logic [xlen-1:0] storeAddr,
    output logic [xlen-1:0] storeData
);

    logic [xlen-1:0] dmem [dmemWords];
    logic [xlen-1:0] opB, pc4, aluResult, memData;
    logic            isZero, overflow, lessThan, taken;

    assign opB = (aluSrc == srcReg) ? rs2Data : imm;
    assign pc4 = pc + 32'd4;

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = rs1Data + opB;
            aluSub:  aluResult = rs1Data - opB;
            aluLink: aluResult = pc4;
            aluFunct: begin
                if (aluSrc == srcUpper) begin
                    aluResult = opB;  // lui.
                end else begin
                    case (funct3)
                        // funct7 bit 30 only means sub for register operands.
                        f3Add:   aluResult = (aluSrc == srcReg && funct7b30) ?
                                             rs1Data - opB : rs1Data + opB;
                        f3Sll:   aluResult = rs1Data << opB[4:0];
                        f3Slt:   aluResult = {31'b0, $signed(rs1Data) < $signed(opB)};
                        f3Xor:   aluResult = rs1Data ^ opB;
                        f3Srl:   aluResult = rs1Data >> opB[4:0];
                        f3Or:    aluResult = rs1Data | opB;
                        f3And:   aluResult = rs1Data & opB;
                        default: aluResult = '0;
                    endcase
                end
            end
            default: aluResult = '0;
        endcase
    end

    // signed compare from the sign of rs1 - rs2, corrected for overflow.
    assign isZero   = (aluResult == '0);
    assign overflow = (rs1Data[31] != opB[31]) && (aluResult[31] != rs1Data[31]);
    assign lessThan = aluResult[31] ^ overflow;

    always_comb begin
        case (funct3)
            f3Beq:   taken = isZero;
            f3Bne:   taken = !isZero;
            f3Blt:   taken = lessThan;
            f3Bge:   taken = !lessThan;
            default: taken = 1'b0;
        endcase
    end

    assign redirect   = dValid && ((branch && taken) || jal || jalr);
    assign redirectPc = jalr ? ((rs1Data + imm) & ~32'd1) : pc + imm;

    assign memData = dmem[aluResult[dmemAw+1:2]];

    always_ff @(posedge clk) begin
        if (storeEn)
            dmem[aluResult[dmemAw+1:2]] <= rs2Data;
    end

    always_comb begin
        case (resultSrc)
            resMem:  wbData = memData;
            resAlu:  wbData = aluResult;
            resPc4:  wbData = pc4;
            default: wbData = '0;
        endcase
    end

    assign wbEn = dValid && regWrite;
    assign wbRd = rd;

    assign retire         = dValid;
    assign retirePc       = pc;
    assign retireRegWrite = wbEn;  // set even for rd = x0.
    assign retireRd       = rd;
    assign retireData     = wbData;

    assign storeEn   = dValid && memWrite;
    assign storeAddr = aluResult;
    assign storeData = rs2Data;

endmodule

//--- src/fetchStage.sv
`timescale 1ns/1ns

module fetchStage import rvPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              imemWe,
    input  logic [imemAw-1:0] imemAddr,
    input  logic [xlen-1:0]   imemData,
    input  logic              redirect,
    input  logic [xlen-1:0]   redirectPc,
    output logic [xlen-1:0]   pc,
    output logic [xlen-1:0]   instr,
    output logic              fValid
);

    logic [xlen-1:0] imem [imemWords];
    logic [xlen-1:0] fetchPc;  // address being fetched this cycle.

    // load port, only driven while reset is held.
    always_ff @(posedge clk) begin
        if (imemWe)
            imem[imemAddr] <= imemData;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchPc <= '0;
            fValid  <= 1'b0;
        end else begin
            fetchPc <= redirect ? redirectPc : fetchPc + 32'd4;
            fValid  <= !redirect;  // wrong-path word is dropped.
        end
    end

    always_ff @(posedge clk) begin
        pc    <= fetchPc;
        instr <= imem[fetchPc[imemAw+1:2]];
    end

endmodule

//--- src/mainController.sv
`timescale 1ns/1ns

module mainController import rvPkg::*; (
    input  opcodeT    opcode,
    output logic      regWrite,
    output logic      memWrite,
    output logic      branch,
    output logic      jal,
    output logic      jalr,
    output aluSrcT    aluSrc,
    output aluOpT     aluOp,
    output immKindT   immKind,
    output resultSrcT resultSrc
);

    always_comb begin
        // inactive unless the opcode says otherwise.
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        jal       = 1'b0;
        jalr      = 1'b0;
        aluSrc    = srcReg;
        aluOp     = aluAdd;
        immKind   = immI;
        resultSrc = resNone;

        case (opcode)
            opR: begin
                regWrite  = 1'b1;
                aluOp     = aluFunct;
                resultSrc = resAlu;
            end
            opI: begin
                regWrite  = 1'b1;
                aluSrc    = srcImm;
                aluOp     = aluFunct;
                resultSrc = resAlu;
            end
            opS: begin
                memWrite = 1'b1;
                aluSrc   = srcImm;
                immKind  = immS;
            end
            opB: begin
                branch  = 1'b1;
                aluOp   = aluSub;  // compares rs1 against rs2.
                immKind = immB;
            end
            opU: begin
                regWrite  = 1'b1;
                aluSrc    = srcUpper;
                aluOp     = aluFunct;
                immKind   = immU;
                resultSrc = resAlu;
            end
            opJ: begin
                jal       = 1'b1;
                regWrite  = 1'b1;
                aluSrc    = srcUpper;
                aluOp     = aluLink;
                immKind   = immJ;
                resultSrc = resPc4;
            end
            opLw: begin
                regWrite  = 1'b1;
                aluSrc    = srcImm;
                resultSrc = resMem;
            end
            opJalr: begin
                jalr      = 1'b1;
                regWrite  = 1'b1;
                aluSrc    = srcImm;
                aluOp     = aluLink;
                resultSrc = resPc4;
            end
            default: ;  // unknown opcode retires as a no-op.
        endcase
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/1ns

module regFile import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic            wbEn,
    input  logic [4:0]      wbRd,
    input  logic [xlen-1:0] wbData,
    output logic [xlen-1:0] rs1Data,
    output logic [xlen-1:0] rs2Data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wbEn && wbRd != 5'd0) begin
            regs[wbRd] <= wbData;
        end
    end

    // same-cycle write is passed through to the readers.
    assign rs1Data = (rs1 == 5'd0) ? '0 : (wbEn && wbRd == rs1) ? wbData : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : (wbEn && wbRd == rs2) ? wbData : regs[rs2];

endmodule

//--- src/rvCore.sv
`timescale 1ns/1ns

module rvCore import rvPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              imemWe,
    input  logic [imemAw-1:0] imemAddr,
    input  logic [xlen-1:0]   imemData,
    output logic              retire,
    output logic [xlen-1:0]   retirePc,
    output logic              retireRegWrite,
    output logic [4:0]        retireRd,
    output logic [xlen-1:0]   retireData,
    output logic              storeEn,
    output logic [xlen-1:0]   storeAddr,
    output logic [xlen-1:0]   storeData
);

    logic [xlen-1:0] fPc, fInstr;
    logic            fValid, dValid;
    logic            redirect;
    logic [xlen-1:0] redirectPc;
    logic            wbEn;
    logic [4:0]      wbRd;
    logic [xlen-1:0] wbData;

    // decode to execute bundle.
    logic [xlen-1:0] exPc, exRs1Data, exRs2Data, exImm;
    logic [2:0]      exFunct3;
    logic            exFunct7b30;
    logic [4:0]      exRd;
    logic            exRegWrite, exMemWrite, exBranch, exJal, exJalr;
    aluSrcT          exAluSrc;
    aluOpT           exAluOp;
    resultSrcT       exResultSrc;

    fetchStage fetch (
        .clk(clk), .rstN(rstN),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .redirect(redirect), .redirectPc(redirectPc),
        .pc(fPc), .instr(fInstr), .fValid(fValid)
    );

    decodeStage decode (
        .clk(clk), .rstN(rstN),
        .pc(fPc), .instr(fInstr), .fValid(fValid), .redirect(redirect),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData),
        .exPc(exPc), .exRs1Data(exRs1Data), .exRs2Data(exRs2Data), .exImm(exImm),
        .exFunct3(exFunct3), .exFunct7b30(exFunct7b30), .exRd(exRd),
        .exRegWrite(exRegWrite), .exMemWrite(exMemWrite), .exBranch(exBranch),
        .exJal(exJal), .exJalr(exJalr), .exAluSrc(exAluSrc), .exAluOp(exAluOp),
        .exResultSrc(exResultSrc), .dValid(dValid)
    );

    executeStage execute (
        .clk(clk),
        .pc(exPc), .rs1Data(exRs1Data), .rs2Data(exRs2Data), .imm(exImm),
        .funct3(exFunct3), .funct7b30(exFunct7b30), .rd(exRd),
        .regWrite(exRegWrite), .memWrite(exMemWrite), .branch(exBranch),
        .jal(exJal), .jalr(exJalr), .aluSrc(exAluSrc), .aluOp(exAluOp),
        .resultSrc(exResultSrc), .dValid(dValid),
        .redirect(redirect), .redirectPc(redirectPc),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData),
        .retire(retire), .retirePc(retirePc), .retireRegWrite(retireRegWrite),
        .retireRd(retireRd), .retireData(retireData),
        .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData)
    );

endmodule

//--- src/rvPkg.sv
package rvPkg;

    // datapath and memory sizes.
    localparam int xlen      = 32;
    localparam int imemWords = 256;
    localparam int dmemWords = 256;
    localparam int imemAw    = $clog2(imemWords);  // word address width.
    localparam int dmemAw    = $clog2(dmemWords);

    typedef enum logic [6:0] {
        opR    = 7'b0110011,
        opI    = 7'b0010011,
        opS    = 7'b0100011,
        opB    = 7'b1100011,
        opU    = 7'b0110111,  // lui only.
        opJ    = 7'b1101111,
        opLw   = 7'b0000011,
        opJalr = 7'b1100111
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd   = 3'b000,  // address calculation.
        aluSub   = 3'b001,  // branch compare.
        aluFunct = 3'b010,  // decoded from funct3 and funct7.
        aluLink  = 3'b011   // pc+4.
    } aluOpT;

    typedef enum logic [1:0] {
        srcReg   = 2'b00,
        srcImm   = 2'b01,
        srcUpper = 2'b10
    } aluSrcT;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immU = 3'b011,
        immJ = 3'b100
    } immKindT;

    typedef enum logic [1:0] {
        resNone = 2'b00,
        resMem  = 2'b01,
        resAlu  = 2'b10,
        resPc4  = 2'b11
    } resultSrcT;

    // alu functions.
    localparam logic [2:0] f3Add = 3'b000;  // add or sub.
    localparam logic [2:0] f3Sll = 3'b001;
    localparam logic [2:0] f3Slt = 3'b010;
    localparam logic [2:0] f3Xor = 3'b100;
    localparam logic [2:0] f3Srl = 3'b101;
    localparam logic [2:0] f3Or  = 3'b110;
    localparam logic [2:0] f3And = 3'b111;

    // branch conditions.
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Blt = 3'b100;
    localparam logic [2:0] f3Bge = 3'b101;

endpackage

//--- tests/rvCoreTb.sv
`timescale 1ns/1ns

module rvCoreTb import rvPkg::*; ();

    localparam int resetCycles = 10;
    localparam int driveDelay  = 10;  // ns after the rising edge.
    localparam int waitLimit   = 20;  // cycles allowed between two retires.

    typedef struct {
        logic [xlen-1:0] pc;
        logic            wr;
        logic [4:0]      rd;
        logic [xlen-1:0] value;  // write-back value, or store data for sw.
        logic            st;
        logic [xlen-1:0] addr;
    } retireT;

    logic              clk = 1'b0;
    logic              rstN;
    logic              imemWe;
    logic [imemAw-1:0] imemAddr;
    logic [xlen-1:0]   imemData;
    logic              retire, retireRegWrite, storeEn;
    logic [xlen-1:0]   retirePc, retireData, storeAddr, storeData;
    logic [4:0]        retireRd;

    logic [xlen-1:0] prog [$];
    retireT          expQ [$];
    int              mismatches = 0;
    int              timeouts = 0;

    rvCore UUT (
        .clk(clk), .rstN(rstN),
        .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .retire(retire), .retirePc(retirePc), .retireRegWrite(retireRegWrite),
        .retireRd(retireRd), .retireData(retireData),
        .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData)
    );

    always #50 clk = ~clk;

    // instruction formats.
    function automatic logic [31:0] rType(logic f7b30, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {1'b0, f7b30, 5'b0, rs2, rs1, f3, rd, opR};
    endfunction

    function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, opcodeT op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opS};
    endfunction

    function automatic logic [31:0] bType(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opB};
    endfunction

    function automatic logic [31:0] uType(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, opU};
    endfunction

    function automatic logic [31:0] jType(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJ};
    endfunction

    function automatic retireT makeRetire(logic [xlen-1:0] pc, logic wr, logic [4:0] rd,
                                          logic [xlen-1:0] value, logic st,
                                          logic [xlen-1:0] addr);
        retireT r;
        r.pc    = pc;
        r.wr    = wr;
        r.rd    = rd;
        r.value = value;
        r.st    = st;
        r.addr  = addr;
        return r;
    endfunction

    task automatic checkWord(input string name, input int idx,
                             input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s at retire %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
        end
    endtask

    task automatic checkReg(input string name, input int idx,
                            input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s at retire %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input int idx, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s at retire %0d: got 0x%h, expected 0x%h", name, idx, got, exp);
        end
    endtask

    // samples on the falling edge, where the execute outputs are settled.
    task automatic waitRetire(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            if (retire === 1'b1)
                seen = 1'b1;
        end
    endtask

    initial begin
        logic seen;
        rstN     = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;

        prog.push_back(iType(12'd5, 0, f3Add, 1, opI));       // 00 addi x1, x0, 5.
        prog.push_back(iType(12'd3, 1, f3Add, 2, opI));       // 04 addi x2, x1, 3.
        prog.push_back(rType(0, 1, 2, f3Add, 3));             // 08 add x3, x2, x1.
        prog.push_back(rType(1, 1, 3, f3Add, 4));             // 0c sub x4, x3, x1.
        prog.push_back(iType(12'h0ff, 4, f3Xor, 5, opI));     // 10 xori.
        prog.push_back(rType(0, 3, 5, f3And, 6));             // 14 and.
        prog.push_back(rType(0, 2, 6, f3Or, 7));              // 18 or.
        prog.push_back(iType(12'd4, 7, f3Sll, 8, opI));       // 1c slli.
        prog.push_back(rType(0, 1, 8, f3Srl, 9));             // 20 srl.
        prog.push_back(rType(0, 8, 9, f3Slt, 10));            // 24 slt.
        prog.push_back(iType(12'hffc, 0, f3Add, 11, opI));    // 28 addi x11, x0, -4.
        prog.push_back(rType(0, 1, 11, f3Slt, 12));           // 2c slt, signed.
        prog.push_back(uType(20'h12345, 13));                 // 30 lui.
        prog.push_back(sType(12'd4, 13, 2));                  // 34 sw x13, 4(x2).
        prog.push_back(iType(12'd4, 2, 3'b010, 14, opLw));    // 38 lw x14, 4(x2).
        prog.push_back(bType(13'd12, 1, 1, f3Beq));           // 3c beq taken.
        prog.push_back(iType(12'd1, 0, f3Add, 15, opI));      // 40 skipped.
        prog.push_back(iType(12'd2, 0, f3Add, 15, opI));      // 44 skipped.
        prog.push_back(bType(13'd12, 1, 11, f3Blt));          // 48 blt taken.
        prog.push_back(iType(12'd3, 0, f3Add, 15, opI));      // 4c skipped.
        prog.push_back(iType(12'd4, 0, f3Add, 15, opI));      // 50 skipped.
        prog.push_back(bType(13'd8, 1, 1, f3Bne));            // 54 bne not taken.
        prog.push_back(bType(13'd8, 1, 11, f3Bge));           // 58 bge not taken.
        prog.push_back(iType(12'd7, 1, f3Add, 0, opI));       // 5c addi x0, x1, 7.
        prog.push_back(rType(0, 1, 0, f3Add, 15));            // 60 add x15, x0, x1.
        prog.push_back(jType(21'd12, 16));                    // 64 jal x16, +12.
        prog.push_back(iType(12'd9, 0, f3Add, 17, opI));      // 68 skipped.
        prog.push_back(iType(12'd9, 0, f3Add, 17, opI));      // 6c skipped.
        prog.push_back(iType(12'h081, 0, f3Add, 18, opI));    // 70 addi x18, x0, 0x81.
        prog.push_back(iType(12'd0, 18, 3'b000, 19, opJalr)); // 74 jalr x19, 0(x18).
        prog.push_back(iType(12'd9, 0, f3Add, 17, opI));      // 78 skipped.
        prog.push_back(iType(12'd9, 0, f3Add, 17, opI));      // 7c skipped.
        prog.push_back(iType(12'd1, 19, f3Add, 20, opI));     // 80 addi.
        prog.push_back(iType(12'h100, 20, f3Or, 21, opI));    // 84 ori.
        prog.push_back(iType(12'h0f0, 21, f3And, 22, opI));   // 88 andi.
        prog.push_back(iType(12'd4, 22, f3Srl, 23, opI));     // 8c srli.
        prog.push_back(rType(0, 1, 23, f3Sll, 24));           // 90 sll.
        prog.push_back(rType(0, 7, 24, f3Xor, 25));           // 94 xor.
        prog.push_back(jType(21'd0, 0));                      // 98 jal x0, 0.

        // pc, write flag, rd, value, store flag, store address.
        expQ.push_back(makeRetire(32'h00, 1, 1, 32'h5, 0, 0));
        expQ.push_back(makeRetire(32'h04, 1, 2, 32'h8, 0, 0));
        expQ.push_back(makeRetire(32'h08, 1, 3, 32'hd, 0, 0));
        expQ.push_back(makeRetire(32'h0c, 1, 4, 32'h8, 0, 0));
        expQ.push_back(makeRetire(32'h10, 1, 5, 32'hf7, 0, 0));
        expQ.push_back(makeRetire(32'h14, 1, 6, 32'h5, 0, 0));
        expQ.push_back(makeRetire(32'h18, 1, 7, 32'hd, 0, 0));
        expQ.push_back(makeRetire(32'h1c, 1, 8, 32'hd0, 0, 0));
        expQ.push_back(makeRetire(32'h20, 1, 9, 32'h6, 0, 0));
        expQ.push_back(makeRetire(32'h24, 1, 10, 32'h1, 0, 0));
        expQ.push_back(makeRetire(32'h28, 1, 11, 32'hffff_fffc, 0, 0));
        expQ.push_back(makeRetire(32'h2c, 1, 12, 32'h1, 0, 0));
        expQ.push_back(makeRetire(32'h30, 1, 13, 32'h1234_5000, 0, 0));
        expQ.push_back(makeRetire(32'h34, 0, 0, 32'h1234_5000, 1, 32'hc));
        expQ.push_back(makeRetire(32'h38, 1, 14, 32'h1234_5000, 0, 0));
        expQ.push_back(makeRetire(32'h3c, 0, 0, 0, 0, 0));
        expQ.push_back(makeRetire(32'h48, 0, 0, 0, 0, 0));
        expQ.push_back(makeRetire(32'h54, 0, 0, 0, 0, 0));
        expQ.push_back(makeRetire(32'h58, 0, 0, 0, 0, 0));
        expQ.push_back(makeRetire(32'h5c, 1, 0, 32'hc, 0, 0));
        expQ.push_back(makeRetire(32'h60, 1, 15, 32'h5, 0, 0));
        expQ.push_back(makeRetire(32'h64, 1, 16, 32'h68, 0, 0));
        expQ.push_back(makeRetire(32'h70, 1, 18, 32'h81, 0, 0));
        expQ.push_back(makeRetire(32'h74, 1, 19, 32'h78, 0, 0));
        expQ.push_back(makeRetire(32'h80, 1, 20, 32'h79, 0, 0));
        expQ.push_back(makeRetire(32'h84, 1, 21, 32'h179, 0, 0));
        expQ.push_back(makeRetire(32'h88, 1, 22, 32'h70, 0, 0));
        expQ.push_back(makeRetire(32'h8c, 1, 23, 32'h7, 0, 0));
        expQ.push_back(makeRetire(32'h90, 1, 24, 32'he0, 0, 0));
        expQ.push_back(makeRetire(32'h94, 1, 25, 32'hed, 0, 0));
        expQ.push_back(makeRetire(32'h98, 1, 0, 32'h9c, 0, 0));
        expQ.push_back(makeRetire(32'h98, 1, 0, 32'h9c, 0, 0));

        // reset lasts the longer of the reset time and the program load.
        for (int i = 0; i < resetCycles || i < prog.size(); i++) begin
            @(posedge clk);
            #driveDelay;
            imemWe = (i < prog.size());
            if (i < prog.size()) begin
                imemAddr = imemAw'(i);
                imemData = prog[i];
            end
        end
        @(posedge clk);
        #driveDelay;
        imemWe = 1'b0;
        rstN   = 1'b1;

        for (int i = 0; i < expQ.size(); i++) begin
            waitRetire(seen);
            if (!seen) begin
                timeouts++;
                $display("Retire %0d, expected at pc %h, never came.", i, expQ[i].pc);
                break;
            end
            checkWord("retirePc", i, retirePc, expQ[i].pc);
            checkFlag("retireRegWrite", i, retireRegWrite, expQ[i].wr);
            checkFlag("storeEn", i, storeEn, expQ[i].st);
            if (expQ[i].wr) begin
                checkReg("retireRd", i, retireRd, expQ[i].rd);
                checkWord("retireData", i, retireData, expQ[i].value);
            end
            if (expQ[i].st) begin
                checkWord("storeAddr", i, storeAddr, expQ[i].addr);
                checkWord("storeData", i, storeData, expQ[i].value);
            end
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tests/rvCore_sva.sv
`timescale 1ns/1ns

module rvCoreSva import rvPkg::*; (
    input logic clk,
    input logic rstN,
    input logic retire,
    input logic retireRegWrite,
    input logic storeEn,
    input logic redirect
);

    // the first reset edge still sees the flops before they clear.
    property quietInReset;
        @(posedge clk) (!rstN ##1 !rstN) |-> (!retire && !storeEn);
    endproperty

    // a store retires and writes no register.
    property storeRetires;
        @(posedge clk) disable iff (!rstN) storeEn |-> (retire && !retireRegWrite);
    endproperty

    // the two younger instructions are flushed.
    property flushAfterRedirect;
        @(posedge clk) disable iff (!rstN) redirect |=> !retire [*2];
    endproperty

    quietInResetA: assert property (quietInReset)
        else $error("retire or storeEn high while reset is held");
    storeRetiresA: assert property (storeRetires)
        else $error("storeEn high without retire, or with a register write");
    flushAfterRedirectA: assert property (flushAfterRedirect)
        else $error("retire within two cycles of a redirect");

endmodule

bind rvCore rvCoreSva sva (
    .clk(clk), .rstN(rstN), .retire(retire), .retireRegWrite(retireRegWrite),
    .storeEn(storeEn), .redirect(redirect)
);
